/* hdl/rv_core_pkg.sv */
package rv_core_pkg;

    // data path width
    localparam int XLEN = 64;

    // the one SYSTEM encoding we accept
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // alu functions
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    // writeback source select
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK
    } wb_src_t;

    typedef logic [4:0] reg_idx_t;

endpackage

/* hdl/rv_pipe_if.sv */
// decode to execute bundle
interface ex_bus_if;
    import rv_core_pkg::*;

    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] imm;
    // rd of zero means no register write
    reg_idx_t        rd;
    alu_op_t         alu_op;
    wb_src_t         wb_src;
    logic            use_imm;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            branch_ne;
    logic            is_jal;
    logic            is_done;
    logic            err;

    modport src (output valid, pc, src1, src2, imm, rd, alu_op, wb_src, use_imm,
                  is_load, is_store, is_branch, branch_ne, is_jal, is_done, err);
    modport sink (input valid, pc, src1, src2, imm, rd, alu_op, wb_src, use_imm,
                  is_load, is_store, is_branch, branch_ne, is_jal, is_done, err);
endinterface

// execute to memory/writeback bundle
interface mw_bus_if;
    import rv_core_pkg::*;

    logic            valid;
    // address for loads and stores, else the value to write back
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] store_data;
    reg_idx_t        rd;
    logic            reg_wr;
    wb_src_t         wb_src;
    logic            is_load;
    logic            is_store;
    logic [XLEN-1:0] nxtpc;
    logic            is_done;
    logic            err;

    modport src (output valid, result, store_data, rd, reg_wr, wb_src,
                  is_load, is_store, nxtpc, is_done, err);
    modport sink (input valid, result, store_data, rd, reg_wr, wb_src,
                  is_load, is_store, nxtpc, is_done, err);
endinterface

/* hdl/rv_fetch.sv */
module rv_fetch #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         redirect,
    input  logic [rv_core_pkg::XLEN-1:0] target,
    input  logic                         halt,
    output logic [rv_core_pkg::XLEN-1:0] pc_rd
);
    import rv_core_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc_rd <= RESET_PC;
        end else if (halt) begin
            // frozen once the program has ended
            pc_rd <= pc_rd;
        end else if (redirect) begin
            // redirect wins over a decode stall
            pc_rd <= target;
        end else if (!stall) begin
            pc_rd <= pc_rd + XLEN'(4);
        end
    end

    // branch and jal targets from execute must keep word alignment
    pc_aligned: assert property (@(posedge clk) disable iff (!rst)
        pc_rd[1:0] == 2'b00);

endmodule

/* hdl/rv_regfile.sv */
module rv_regfile (
    input  logic                         clk,
    input  logic                         rst,
    input  rv_core_pkg::reg_idx_t        rs1,
    input  rv_core_pkg::reg_idx_t        rs2,
    output logic [rv_core_pkg::XLEN-1:0] src1,
    output logic [rv_core_pkg::XLEN-1:0] src2,
    output logic                         rs1_hazard,
    output logic                         rs2_hazard,
    input  logic                         wen,
    input  rv_core_pkg::reg_idx_t        rd,
    input  logic [rv_core_pkg::XLEN-1:0] data,
    input  rv_core_pkg::reg_idx_t        ex_rd,
    input  logic                         ex_wen,
    input  logic                         ex_is_load,
    input  logic [rv_core_pkg::XLEN-1:0] ex_data,
    input  rv_core_pkg::reg_idx_t        m_rd,
    input  logic                         m_wen,
    input  logic [rv_core_pkg::XLEN-1:0] m_data
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [32];

    // youngest writer first, then the array
    function automatic logic [XLEN-1:0] read_src(input reg_idx_t rs);
        if (rs == '0)
            return '0;
        if (ex_wen && ex_rd == rs)
            return ex_data;
        if (m_wen && m_rd == rs)
            return m_data;
        return regs[rs];
    endfunction

    always_comb begin
        src1 = read_src(rs1);
        src2 = read_src(rs2);
    end

    // load in execute has no data yet
    assign rs1_hazard = ex_wen && ex_is_load && ex_rd == rs1 && rs1 != '0;
    assign rs2_hazard = ex_wen && ex_is_load && ex_rd == rs2 && rs2 != '0;

    // x0 never written
    always_ff @(posedge clk) begin
        if (rst && wen && rd != '0)
            regs[rd] <= data;
    end

endmodule

/* hdl/rv_decode.sv */
module rv_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [31:0]                  instr,
    input  logic                         instr_valid,
    input  logic                         instr_error,
    input  logic [rv_core_pkg::XLEN-1:0] pc,
    input  logic                         flush,
    input  logic                         mw_hold,
    input  logic                         halt,
    input  logic [rv_core_pkg::XLEN-1:0] src1,
    input  logic [rv_core_pkg::XLEN-1:0] src2,
    input  logic                         rs1_hazard,
    input  logic                         rs2_hazard,
    output logic                         stall,
    ex_bus_if.src                        ex
);
    import rv_core_pkg::*;

    opcode_t         op;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
    alu_op_t         alu_op;
    wb_src_t         wb_src;
    reg_idx_t        rd;
    logic            use_imm, use_rs1, use_rs2;
    logic            is_load, is_store, is_branch, is_jal, is_done;
    logic            bad, err, load_use, take;

    assign op     = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediate formats
    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm       = imm_i;
        alu_op    = ALU_ADD;
        wb_src    = WB_ALU;
        rd        = instr[11:7];
        use_imm   = 1'b0;
        use_rs1   = 1'b1;
        use_rs2   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_done   = 1'b0;
        bad       = 1'b0;
        case (op)
            OPC_OP: begin
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = ALU_ADD;
                    {7'h20, 3'b000}: alu_op = ALU_SUB;
                    {7'h00, 3'b100}: alu_op = ALU_XOR;
                    {7'h00, 3'b110}: alu_op = ALU_OR;
                    {7'h00, 3'b111}: alu_op = ALU_AND;
                    default:         bad = 1'b1;
                endcase
            end
            // addi only
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                bad     = funct3 != 3'b000;
            end
            OPC_LUI: begin
                use_rs1 = 1'b0;
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = ALU_PASS_B;
            end
            // doubleword accesses only
            OPC_LOAD: begin
                use_imm = 1'b1;
                is_load = 1'b1;
                wb_src  = WB_LOAD;
                bad     = funct3 != 3'b011;
            end
            OPC_STORE: begin
                use_imm  = 1'b1;
                use_rs2  = 1'b1;
                imm      = imm_s;
                is_store = 1'b1;
                rd       = '0;
                bad      = funct3 != 3'b011;
            end
            // beq and bne, funct3[0] picks ne
            OPC_BRANCH: begin
                use_rs2   = 1'b1;
                imm       = imm_b;
                is_branch = 1'b1;
                rd        = '0;
                bad       = funct3[2:1] != 2'b00;
            end
            OPC_JAL: begin
                use_rs1 = 1'b0;
                imm     = imm_j;
                is_jal  = 1'b1;
                wb_src  = WB_LINK;
            end
            OPC_SYSTEM: begin
                use_rs1 = 1'b0;
                rd      = '0;
                is_done = instr == INSTR_EBREAK;
                bad     = instr != INSTR_EBREAK;
            end
            default: bad = 1'b1;
        endcase
        err = bad || instr_error;
        // a faulting instruction only carries its error to retire
        if (err) begin
            rd        = '0;
            is_load   = 1'b0;
            is_store  = 1'b0;
            is_branch = 1'b0;
            is_jal    = 1'b0;
            is_done   = 1'b0;
        end
    end

    assign load_use = instr_valid && ((use_rs1 && rs1_hazard) || (use_rs2 && rs2_hazard));
    // fetch also holds while no instruction is presented
    assign stall    = load_use || mw_hold || !instr_valid;
    assign take     = instr_valid && !flush && !load_use && !halt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ex.valid <= 1'b0;
        end else if (!mw_hold) begin
            // bubble unless the instruction is taken
            ex.valid     <= take;
            ex.pc        <= pc;
            ex.src1      <= src1;
            ex.src2      <= src2;
            ex.imm       <= imm;
            ex.rd        <= rd;
            ex.alu_op    <= alu_op;
            ex.wb_src    <= wb_src;
            ex.use_imm   <= use_imm;
            ex.is_load   <= is_load;
            ex.is_store  <= is_store;
            ex.is_branch <= is_branch;
            ex.branch_ne <= funct3[0];
            ex.is_jal    <= is_jal;
            ex.is_done   <= is_done;
            ex.err       <= err;
        end
    end

endmodule

/* hdl/rv_execute.sv */
module rv_execute (
    input  logic                         clk,
    input  logic                         rst,
    ex_bus_if.sink                       ex,
    mw_bus_if.src                        mw,
    input  logic                         mw_hold,
    output logic                         redirect,
    output logic [rv_core_pkg::XLEN-1:0] target,
    output rv_core_pkg::reg_idx_t        ex_rd,
    output logic                         ex_wen,
    output logic                         ex_is_load,
    output logic [rv_core_pkg::XLEN-1:0] ex_data
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] op_b, alu_res, link;
    logic            taken;

    assign op_b = ex.use_imm ? ex.imm : ex.src2;

    always_comb begin
        case (ex.alu_op)
            ALU_SUB:    alu_res = ex.src1 - op_b;
            ALU_AND:    alu_res = ex.src1 & op_b;
            ALU_OR:     alu_res = ex.src1 | op_b;
            ALU_XOR:    alu_res = ex.src1 ^ op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = ex.src1 + op_b;
        endcase
    end

    // branch_ne inverts the equality test
    assign taken  = ex.is_jal || (ex.is_branch && ((ex.src1 == ex.src2) != ex.branch_ne));
    assign target = ex.pc + ex.imm;
    assign link   = ex.pc + XLEN'(4);
    // wait until the branch can actually leave execute
    assign redirect = ex.valid && taken && !mw_hold;

    // forwarding view of this stage
    assign ex_rd      = ex.rd;
    assign ex_wen     = ex.valid && ex.rd != '0;
    assign ex_is_load = ex.is_load;
    assign ex_data    = (ex.wb_src == WB_LINK) ? link : alu_res;

    always_ff @(posedge clk) begin
        if (!rst) begin
            mw.valid <= 1'b0;
        end else if (!mw_hold) begin
            mw.valid      <= ex.valid;
            mw.result     <= ex_data;
            mw.store_data <= ex.src2;
            mw.rd         <= ex.rd;
            mw.reg_wr     <= ex.rd != '0;
            mw.wb_src     <= ex.wb_src;
            mw.is_load    <= ex.is_load;
            mw.is_store   <= ex.is_store;
            mw.nxtpc      <= taken ? target : link;
            mw.is_done    <= ex.is_done;
            mw.err        <= ex.err;
        end
    end

endmodule

/* hdl/rv_memwb.sv */
module rv_memwb (
    input  logic                         clk,
    input  logic                         rst,
    mw_bus_if.sink                       mw,
    input  logic [rv_core_pkg::XLEN-1:0] data_Rd,
    input  logic                         data_Rd_valid,
    input  logic                         data_Rd_error,
    output logic                         MemRd,
    output logic                         MemWr,
    output logic [rv_core_pkg::XLEN-1:0] addr,
    output logic [rv_core_pkg::XLEN-1:0] data_Wr,
    output logic                         mw_hold,
    output logic                         wen,
    output rv_core_pkg::reg_idx_t        rd,
    output logic [rv_core_pkg::XLEN-1:0] data,
    output rv_core_pkg::reg_idx_t        m_rd,
    output logic                         m_wen,
    output logic [rv_core_pkg::XLEN-1:0] m_data,
    output logic                         out_valid,
    output logic [rv_core_pkg::XLEN-1:0] pc_nxt,
    output logic                         done,
    output logic                         error,
    output logic                         halt
);
    import rv_core_pkg::*;

    logic active, retire, ld_err;

    // nothing past the end of the program takes effect
    assign active = mw.valid && !halt;

    assign MemRd   = active && mw.is_load;
    assign MemWr   = active && mw.is_store;
    assign addr    = mw.result;
    assign data_Wr = mw.store_data;

    // a load sits here until the data port answers
    assign mw_hold = MemRd && !data_Rd_valid && !data_Rd_error;
    assign retire  = active && !mw_hold;
    assign ld_err  = mw.is_load && data_Rd_error;

    assign data   = (mw.wb_src == WB_LOAD) ? data_Rd : mw.result;
    assign rd     = mw.rd;
    assign wen    = retire && mw.reg_wr && !ld_err;
    // bypass to decode
    assign m_rd   = mw.rd;
    assign m_wen  = active && mw.reg_wr;
    assign m_data = data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
            halt      <= 1'b0;
        end else begin
            out_valid <= retire;
            done      <= retire && mw.is_done;
            error     <= retire && (mw.err || ld_err);
            if (retire && (mw.is_done || mw.err || ld_err))
                halt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (retire)
            pc_nxt <= mw.nxtpc;
    end

    // decode never marks one instruction as both load and store
    mem_excl: assert property (@(posedge clk) disable iff (!rst) !(MemRd && MemWr));

endmodule

/* hdl/rv_core.sv */
module rv_core #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [31:0]                  instr,
    input  logic                         instr_valid,
    input  logic                         instr_error,
    output logic [rv_core_pkg::XLEN-1:0] pc_rd,
    input  logic [rv_core_pkg::XLEN-1:0] data_Rd,
    input  logic                         data_Rd_valid,
    input  logic                         data_Rd_error,
    output logic                         MemRd,
    output logic                         MemWr,
    output logic [rv_core_pkg::XLEN-1:0] addr,
    output logic [rv_core_pkg::XLEN-1:0] data_Wr,
    output logic                         out_valid,
    output logic [rv_core_pkg::XLEN-1:0] pc_nxt,
    output logic                         done,
    output logic                         error
);
    import rv_core_pkg::*;

    // fetch and decode control
    logic            id_stall, redirect, halt, mw_hold;
    logic [XLEN-1:0] target;
    // register read side
    logic [XLEN-1:0] src1, src2;
    logic            rs1_hazard, rs2_hazard;
    // writeback port
    logic            wb_wen;
    reg_idx_t        wb_rd;
    logic [XLEN-1:0] wb_data;
    // forwarding sources
    reg_idx_t        ex_rd, m_rd;
    logic            ex_wen, ex_is_load, m_wen;
    logic [XLEN-1:0] ex_data, m_data;

    ex_bus_if ex_bus ();
    mw_bus_if mw_bus ();

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst      (rst),
        .stall    (id_stall),
        .redirect (redirect),
        .target   (target),
        .halt     (halt),
        .pc_rd    (pc_rd)
    );

    // source fields straight from the fetched word
    rv_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1        (instr[19:15]),
        .rs2        (instr[24:20]),
        .src1       (src1),
        .src2       (src2),
        .rs1_hazard (rs1_hazard),
        .rs2_hazard (rs2_hazard),
        .wen        (wb_wen),
        .rd         (wb_rd),
        .data       (wb_data),
        .ex_rd      (ex_rd),
        .ex_wen     (ex_wen),
        .ex_is_load (ex_is_load),
        .ex_data    (ex_data),
        .m_rd       (m_rd),
        .m_wen      (m_wen),
        .m_data     (m_data)
    );

    rv_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_error (instr_error),
        .pc          (pc_rd),
        .flush       (redirect),
        .mw_hold     (mw_hold),
        .halt        (halt),
        .src1        (src1),
        .src2        (src2),
        .rs1_hazard  (rs1_hazard),
        .rs2_hazard  (rs2_hazard),
        .stall       (id_stall),
        .ex          (ex_bus)
    );

    rv_execute u_execute (
        .clk        (clk),
        .rst        (rst),
        .ex         (ex_bus),
        .mw         (mw_bus),
        .mw_hold    (mw_hold),
        .redirect   (redirect),
        .target     (target),
        .ex_rd      (ex_rd),
        .ex_wen     (ex_wen),
        .ex_is_load (ex_is_load),
        .ex_data    (ex_data)
    );

    rv_memwb u_memwb (
        .clk           (clk),
        .rst           (rst),
        .mw            (mw_bus),
        .data_Rd       (data_Rd),
        .data_Rd_valid (data_Rd_valid),
        .data_Rd_error (data_Rd_error),
        .MemRd         (MemRd),
        .MemWr         (MemWr),
        .addr          (addr),
        .data_Wr       (data_Wr),
        .mw_hold       (mw_hold),
        .wen           (wb_wen),
        .rd            (wb_rd),
        .data          (wb_data),
        .m_rd          (m_rd),
        .m_wen         (m_wen),
        .m_data        (m_data),
        .out_valid     (out_valid),
        .pc_nxt        (pc_nxt),
        .done          (done),
        .error         (error),
        .halt          (halt)
    );

endmodule

/* bench/tb_rv_core.sv */
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_core_pkg::*;

    localparam logic [XLEN-1:0] START_PC = 64'h0000_0000_8000_0000;

    logic            clk, rst;
    logic [31:0]     instr;
    logic            instr_valid, instr_error;
    logic [XLEN-1:0] pc_rd, data_Rd, addr, data_Wr, pc_nxt;
    logic            data_Rd_valid, data_Rd_error;
    logic            MemRd, MemWr, out_valid, done, error;

    // memory models keyed by byte address
    logic [31:0]     imem [logic [XLEN-1:0]];
    logic [XLEN-1:0] dmem [logic [XLEN-1:0]];
    // expected stores with the oldest first
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];

    logic [31:0] lfsr;
    logic        ld_busy;
    int          ld_wait;
    int          commits;
    int          n_instr;
    bit          running;
    bit          ended;
    // commit outputs seen in the cycle the program ended
    logic [XLEN-1:0] fin_pc;
    int              fin_count;
    logic            fin_done;
    logic            fin_error;

    rv_core #(
        .RESET_PC (START_PC)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .instr_error   (instr_error),
        .pc_rd         (pc_rd),
        .data_Rd       (data_Rd),
        .data_Rd_valid (data_Rd_valid),
        .data_Rd_error (data_Rd_error),
        .MemRd         (MemRd),
        .MemWr         (MemWr),
        .addr          (addr),
        .data_Wr       (data_Wr),
        .out_valid     (out_valid),
        .pc_nxt        (pc_nxt),
        .done          (done),
        .error         (error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr with taps 32 22 2 1
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] a);
        // unwritten locations read as nop
        if (imem.exists(a))
            return imem[a];
        return 32'h0000_0013;
    endfunction

    function automatic logic [XLEN-1:0] load_word(input logic [XLEN-1:0] a);
        if (dmem.exists(a))
            return dmem[a];
        return a ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    task automatic fail_value(input string msg);
        $display("FAIL @%0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_store(input logic [XLEN-1:0] a, input logic [XLEN-1:0] d);
        logic [XLEN-1:0] ea, ed;
        if (exp_addr.size() == 0)
            abort_run($sformatf("unexpected store to %h at %0t", a, $time));
        ea = exp_addr.pop_front();
        ed = exp_data.pop_front();
        if (a !== ea || d !== ed)
            fail_value($sformatf("store %h <= %h, expected %h <= %h", a, d, ea, ed));
    endtask

    task automatic check_commit(input logic [XLEN-1:0] pc);
        if (pc[1:0] !== 2'b00)
            fail_value($sformatf("commit pc_nxt %h not word aligned", pc));
    endtask

    task automatic check_end(input logic [XLEN-1:0] pc, input int count, input int flag);
        if (fin_pc !== pc)
            fail_value($sformatf("end pc_nxt %h, expected %h", fin_pc, pc));
        if (fin_count != count)
            fail_value($sformatf("%0d commits, expected %0d", fin_count, count));
        if (fin_error !== flag[0] || fin_done !== !flag[0])
            fail_value($sformatf("done %b error %b, expected error %0d",
                                 fin_done, fin_error, flag));
    endtask

    // instruction fetch and load answers just after each rising edge
    always @(posedge clk) begin
        #1;
        instr = fetch_word(pc_rd);
        data_Rd_valid = 1'b0;
        if (MemRd) begin
            if (!ld_busy) begin
                ld_busy = 1'b1;
                ld_wait = {take_bit(), take_bit()};
            end
            if (ld_wait == 0) begin
                data_Rd       = load_word(addr);
                data_Rd_valid = 1'b1;
                ld_busy       = 1'b0;
            end else begin
                ld_wait--;
            end
        end
    end

    // outputs are stable mid cycle
    always @(negedge clk) begin
        if (running) begin
            if (out_valid) begin
                commits++;
                check_commit(pc_nxt);
            end
            if (MemWr) begin
                check_store(addr, data_Wr);
                dmem[addr] = data_Wr;
            end
            // done and error only pulse with the last commit
            if (!ended && (done || error)) begin
                ended     = 1'b1;
                fin_pc    = pc_nxt;
                fin_count = commits;
                fin_done  = done;
                fin_error = error;
            end
        end
    end

    task automatic run_program(input logic [XLEN-1:0] end_pc, input int count, input int flag);
        int cycles;
        int limit;
        int seen;
        cycles = 0;
        limit  = 40 * n_instr;
        @(posedge clk);
        #1;
        rst         = 1'b0;
        instr_valid = 1'b0;
        running     = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        ld_busy     = 1'b0;
        commits     = 0;
        ended       = 1'b0;
        fin_pc      = '0;
        fin_count   = 0;
        fin_done    = 1'b0;
        fin_error   = 1'b0;
        running     = 1'b1;
        rst         = 1'b1;
        instr_valid = 1'b1;
        while (!ended) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit)
                abort_run($sformatf("timeout, program did not end in %0d cycles", limit));
        end
        check_end(end_pc, count, flag);
        seen = commits;
        // nothing may retire after the end
        repeat (10) @(posedge clk);
        if (commits != seen)
            abort_run("commit seen after the program ended");
        if (exp_addr.size() != 0)
            abort_run($sformatf("%0d expected stores never happened", exp_addr.size()));
    endtask

    initial begin
        int              fd, code, cnt, flag;
        byte             tag;
        string           line;
        logic [XLEN-1:0] a, v;
        bit              more;
        rst           = 1'b0;
        instr         = '0;
        instr_valid   = 1'b0;
        instr_error   = 1'b0;
        data_Rd       = '0;
        data_Rd_valid = 1'b0;
        data_Rd_error = 1'b0;
        lfsr          = 32'he605_8a12;
        ld_busy       = 1'b0;
        ld_wait       = 0;
        commits       = 0;
        n_instr       = 0;
        running       = 1'b0;
        ended         = 1'b0;
        fd = $fopen("bench/rv_core_patterns.txt", "r");
        if (fd == 0)
            abort_run("cannot open bench/rv_core_patterns.txt");
        more = 1'b1;
        while (more) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                more = 1'b0;
            end else begin
                case (tag)
                    "#": code = $fgets(line, fd);
                    "I": begin
                        code = $fscanf(fd, "%h %h", a, v);
                        imem[a] = v[31:0];
                        n_instr++;
                    end
                    "D": begin
                        code = $fscanf(fd, "%h %h", a, v);
                        dmem[a] = v;
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h", a, v);
                        exp_addr.push_back(a);
                        exp_data.push_back(v);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %d %d", a, cnt, flag);
                        run_program(a, cnt, flag);
                    end
                    "R": begin
                        imem.delete();
                        dmem.delete();
                        n_instr = 0;
                    end
                    default: abort_run($sformatf("bad record tag '%c' in pattern file", tag));
                endcase
            end
        end
        $fclose(fd);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* bench/rv_core_patterns.txt */
# I addr word | D addr value | S addr value (expected store, in order)
# E end pc_nxt, commit count, error flag | R clear memories for next program
I 80000000 00500093
I 80000004 00708113
I 80000008 002081B3
I 8000000C 10303023
I 80000010 20003203
I 80000014 401202B3
I 80000018 10503423
I 8000001C 00108463
I 80000020 10103823
I 80000024 0080036F
I 80000028 10103C23
I 8000002C 12603023
I 80000030 00209463
I 80000034 12103423
I 80000038 123453B7
I 8000003C 0023C433
I 80000040 12803823
I 80000044 00100073
D 00000200 123456789abcdef0
S 00000100 0000000000000011
S 00000108 123456789abcdeeb
S 00000120 0000000080000028
S 00000130 000000001234500c
E 80000048 15 0
R
I 80000000 0F000093
I 80000004 03C00113
I 80000008 0020E1B3
I 8000000C 0020F233
I 80000010 10303023
I 80000014 10403423
I 80000018 FFFFFFFF
I 8000001C 10103823
S 00000100 00000000000000fc
S 00000108 0000000000000030
E 8000001c 7 1

/* files.f */
hdl/rv_core_pkg.sv
hdl/rv_pipe_if.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memwb.sv
hdl/rv_core.sv
bench/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
    -f files.f -o sim_rv_core

# the simulator exits nonzero on $fatal, the log decides
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
grep -q "TB PASSED" sim.log
